/* project.f */
+incdir+include
logic/frame_read_pkg.sv
logic/iter.sv
logic/sync_fifo.sv
logic/axi_read_words.sv
logic/word_sram.sv
logic/frame_read_top.sv
testbench/clk_gen.sv
testbench/tb_frame_read.sv

/* Makefile */
# Verilator build and run of the strided frame reader testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_read
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_frame_read.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frame_read_config.svh"

module tb_frame_read;

  import frame_read_pkg::*;

  localparam int AW         = `FR_ADDR_WIDTH;
  localparam int DW         = `FR_DATA_WIDTH;
  localparam int WORDS      = 1 << AW;
  localparam int WAIT_LIMIT = 200;

  logic          axi_clk;
  logic          axi_resetn;
  rd_req_t       req;
  logic          req_valid;
  logic          req_ready;
  rd_beat_t      beat;
  logic          beat_valid;
  logic          beat_ready;
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  logic [DW-1:0] wr_data;

  // reference copy of the memory, updated with every load through the write port
  logic [DW-1:0] shadow [WORDS];

  clk_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (16)
  ) clk_gen_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn)
  );

  frame_read_top frame_read_top_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string channel);
    $display("timeout at %0t ns: the %s did not respond within %0d cycles",
             $time, channel, WAIT_LIMIT);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on a hung channel");
  endtask

  // every sample below is taken at a rising edge, before the DUT registers update
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    do begin
      @(posedge axi_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("reset line, axi_resetn never rose,");
      end
    end while (!axi_resetn);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    do begin
      @(posedge axi_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("request channel, req_ready never rose,");
      end
    end while (!req_ready);
  endtask

  task automatic drive_request(input logic [AW-1:0] addr, input logic [7:0] len);
    req       <= '{araddr: addr, arlenw: len};
    req_valid <= 1'b1;
  endtask

  // returns on the edge where the request is taken, cycles counts edges waited
  task automatic wait_accept(output int cycles);
    cycles = 0;
    do begin
      @(posedge axi_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("request channel, req_valid was never accepted,");
      end
    end while (!(req_valid && req_ready));
    req_valid <= 1'b0;
  endtask

  task automatic send_request(input logic [AW-1:0] addr, input logic [7:0] len);
    int cycles;
    drive_request(addr, len);
    wait_accept(cycles);
  endtask

  // takes len+1 beats and checks each against the shadow word at addr + k*stride
  task automatic collect_beats(input logic [AW-1:0] addr, input int len,
                               input bit random_ready);
    int            k;
    int            cycles;
    bit            taken;
    logic [AW-1:0] exp_addr;
    for (k = 0; k <= len; k++) begin
      beat_ready <= random_ready ? 1'($urandom & 1) : 1'b1;
      cycles = 0;
      taken  = 1'b0;
      while (!taken) begin
        @(posedge axi_clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          report_timeout("beat channel, beat_valid never met beat_ready,");
        end
        // no new request may be taken while this burst is still open
        check_equal(32'(req_ready), 32'd0, "req_ready while a burst is open");
        // the edge right after a transfer has to show the bubble
        if (k > 0 && cycles == 1) begin
          check_equal(32'(beat_valid), 32'd0, "beat_valid bubble after a transfer");
        end
        taken = beat_valid && beat_ready;
        if (!taken && random_ready) begin
          beat_ready <= 1'($urandom & 1);
        end
      end
      exp_addr = AW'(int'(addr) + k * `FR_STRIDE);
      check_equal(32'(beat.rdata), 32'(shadow[exp_addr]), $sformatf("rdata of beat %0d", k));
      check_equal(32'(beat.rresp), 32'd0, $sformatf("rresp of beat %0d", k));
      check_equal(32'(beat.rlast), 32'(k == len), $sformatf("rlast of beat %0d", k));
    end
    beat_ready <= 1'b0;
  endtask

  // after the last beat the reader is idle again and sends nothing more
  task automatic check_quiet(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge axi_clk);
      check_equal(32'(beat_valid), 32'd0, "beat_valid after the last beat");
      check_equal(32'(req_ready), 32'd1, "req_ready after the last beat");
    end
  endtask

  task automatic load_memory();
    int            a;
    logic [DW-1:0] word;
    for (a = 0; a < WORDS; a++) begin
      word      = DW'($urandom);
      shadow[a] = word;
      wr_en   <= 1'b1;
      wr_addr <= AW'(a);
      wr_data <= word;
      @(posedge axi_clk);
    end
    wr_en <= 1'b0;
  endtask

  task automatic test_reset();
    wait_reset_release();
    check_equal(32'(beat_valid), 32'd0, "beat_valid right after reset");
    check_equal(32'(req_ready), 32'd0, "req_ready while reset was applied");
    wait_idle();
    check_equal(32'(beat_valid), 32'd0, "beat_valid once idle");
  endtask

  task automatic test_single_beat();
    load_memory();
    send_request(8'h3c, 8'd0);
    collect_beats(8'h3c, 0, 1'b0);
    check_quiet(8);
  endtask

  task automatic test_burst8();
    send_request(8'h10, 8'd7);
    collect_beats(8'h10, 7, 1'b0);
    check_quiet(4);
  endtask

  // a random beat_ready lets both FIFOs fill and throttle the memory reads
  task automatic test_backpressure();
    send_request(8'h40, 8'd23);
    collect_beats(8'h40, 23, 1'b1);
    check_quiet(4);
  endtask

  task automatic test_back_to_back();
    int gap;
    send_request(8'd250, 8'd5);
    // the next request already waits on the channel while the first drains
    drive_request(8'd17, 8'd3);
    collect_beats(8'd250, 5, 1'b0);
    wait_accept(gap);
    check_equal(32'(gap), 32'd1, "cycles from the rlast transfer to the next acceptance");
    collect_beats(8'd17, 3, 1'b1);
    send_request(8'd254, 8'd2);
    collect_beats(8'd254, 2, 1'b0);
    check_quiet(4);
  endtask

  initial begin
    void'($urandom(32'h56cc));
    req        <= '0;
    req_valid  <= 1'b0;
    beat_ready <= 1'b0;
    wr_en      <= 1'b0;
    wr_addr    <= '0;
    wr_data    <= '0;

    test_reset();
    test_single_beat();
    test_burst8();
    test_backpressure();
    test_back_to_back();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock and a synchronous reset held low for the first cycles
module clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic axi_clk,
  output logic axi_resetn
);

  initial begin
    axi_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) axi_clk = ~axi_clk;
    end
  end

  // reset is released right after a rising edge so the design leaves it cleanly
  initial begin
    axi_resetn <= 1'b0;
    repeat (RESET_CYCLES) @(posedge axi_clk);
    axi_resetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/frame_read_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frame_read_config.svh"

// strided line reader in front of its word memory
module frame_read_top (
  input  logic                      axi_clk,
  input  logic                      axi_resetn,
  input  frame_read_pkg::rd_req_t   req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output frame_read_pkg::rd_beat_t  beat,
  output logic                      beat_valid,
  input  logic                      beat_ready,
  input  logic                      wr_en,
  input  logic [`FR_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`FR_DATA_WIDTH-1:0] wr_data
);

  import frame_read_pkg::*;

  // reader to memory channel
  logic [`FR_ADDR_WIDTH-1:0] mem_araddr;
  logic                      mem_arvalid;
  logic                      mem_arready;
  mem_r_t                    mem_r;
  logic                      mem_rvalid;
  logic                      mem_rready;

  axi_read_words axi_read_words_i (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .beat        (beat),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_r       (mem_r),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready)
  );

  // the load port goes straight to the memory
  word_sram word_sram_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .araddr     (mem_araddr),
    .arvalid    (mem_arvalid),
    .arready    (mem_arready),
    .r          (mem_r),
    .rvalid     (mem_rvalid),
    .rready     (mem_rready)
  );

endmodule

`default_nettype wire

/* logic/word_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frame_read_config.svh"

// on-chip word memory with a one-cycle write port and a single-beat read channel
module word_sram (
  input  logic                      axi_clk,
  input  logic                      axi_resetn,
  input  logic                      wr_en,
  input  logic [`FR_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`FR_DATA_WIDTH-1:0] wr_data,
  input  logic [`FR_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output frame_read_pkg::mem_r_t    r,
  output logic                      rvalid,
  input  logic                      rready
);

  import frame_read_pkg::*;

  localparam int WORDS = 1 << `FR_ADDR_WIDTH;

  logic [`FR_DATA_WIDTH-1:0] mem [WORDS];

  logic rd_accept;

  // a new read fits when the held response is gone or leaves this cycle
  assign arready   = !rvalid || rready;
  assign rd_accept = arvalid && arready;

  always_ff @(posedge axi_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, the word shows up one cycle after the address is taken
  always_ff @(posedge axi_clk) begin
    if (rd_accept) begin
      r <= '{rdata: mem[araddr], rresp: RESP_OKAY};
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/axi_read_words.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frame_read_config.svh"

// turns one strided burst request into single-beat memory reads
// beat k reads address araddr + k*FR_STRIDE, wrapping modulo the address space
// since the address is the only thing tracked, a burst should stay under the
// number of beats at which the address would come back to its start
module axi_read_words (
  input  logic                        axi_clk,
  input  logic                        axi_resetn,
  input  frame_read_pkg::rd_req_t     req,
  input  logic                        req_valid,
  output logic                        req_ready,
  output frame_read_pkg::rd_beat_t    beat,
  output logic                        beat_valid,
  input  logic                        beat_ready,
  output logic [`FR_ADDR_WIDTH-1:0]   mem_araddr,
  output logic                        mem_arvalid,
  input  logic                        mem_arready,
  input  frame_read_pkg::mem_r_t      mem_r,
  input  logic                        mem_rvalid,
  output logic                        mem_rready
);

  import frame_read_pkg::*;

  localparam int AW = `FR_ADDR_WIDTH;

  typedef enum logic [1:0] {
    IDLE          = 2'b00,
    INIT_BURST    = 2'b01,
    READING_BEATS = 2'b10,
    FINISH_BURST  = 2'b11
  } state_t;

  state_t state;
  state_t next_state;

  // handshake events
  logic burst_start;
  logic beat_read_start;
  logic beat_read_accepted;
  logic beat_read_done;
  logic burst_done;

  // address walk
  logic [AW-1:0] req_max_addr;
  logic [AW-1:0] max_addr_q;
  logic [AW-1:0] addr_max_val;
  logic [AW-1:0] addr;
  logic          addr_last;
  logic          addr_done;

  // FIFO side
  logic       meta_afull;
  logic       meta_last;
  res_entry_t res_w_data;
  logic       res_afull;
  logic       res_r_inc;
  res_entry_t res_r_data;
  logic       res_r_empty;

  // a new read may go out when the address slot is free or frees this cycle
  logic issue_slot;
  logic fifo_room;

  assign burst_start        = (state == IDLE) && req_valid && req_ready;
  assign beat_read_accepted = mem_arvalid && mem_arready;
  assign beat_read_done     = mem_rvalid && mem_rready;
  assign issue_slot         = !mem_arvalid || beat_read_accepted;
  assign fifo_room          = !meta_afull && !res_afull;

  // the result FIFO keeps enough margin for every read in flight
  assign mem_rready = 1'b1;

  always_comb begin
    next_state      = state;
    beat_read_start = 1'b0;
    case (state)
      IDLE: begin
        if (burst_start) begin
          next_state = INIT_BURST;
        end
      end
      // the iterator holds the start address now, both FIFOs are empty
      INIT_BURST: begin
        beat_read_start = 1'b1;
        next_state      = READING_BEATS;
      end
      READING_BEATS: begin
        if (!addr_done) begin
          beat_read_start = issue_slot && fifo_room;
        end else if (issue_slot) begin
          next_state = FINISH_BURST;
        end
      end
      // wait until the caller takes the beat flagged last
      FINISH_BURST: begin
        if (burst_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // req_ready follows the idle state one register behind next_state
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state     <= IDLE;
      req_ready <= 1'b0;
    end else begin
      state     <= next_state;
      req_ready <= (next_state == IDLE);
    end
  end

  // final address of the burst, modulo the address space
  assign req_max_addr = req.araddr + AW'(`FR_STRIDE) * AW'(req.arlenw);

  // the caller may change req once accepted, so the end address is kept here
  always_ff @(posedge axi_clk) begin
    if (burst_start) begin
      max_addr_q <= req_max_addr;
    end
  end

  assign addr_max_val = burst_start ? req_max_addr : max_addr_q;

  iter #(
    .WIDTH   (AW),
    .INC_VAL (`FR_STRIDE)
  ) addr_iter_i (
    .axi_clk  (axi_clk),
    .init     (burst_start),
    .init_val (req.araddr),
    .max_val  (addr_max_val),
    .inc      (beat_read_start),
    .val      (addr),
    .last     (addr_last)
  );

  // set once the read for the final address has been launched
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      addr_done <= 1'b0;
    end else if (burst_start) begin
      addr_done <= 1'b0;
    end else if (beat_read_start && addr_last) begin
      addr_done <= 1'b1;
    end
  end

  // address channel towards the memory
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      mem_arvalid <= 1'b0;
    end else if (beat_read_start) begin
      mem_arvalid <= 1'b1;
    end else if (beat_read_accepted) begin
      mem_arvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (beat_read_start) begin
      mem_araddr <= addr;
    end
  end

  // one last flag per launched read, popped when its word comes back
  sync_fifo #(
    .T               (logic),
    .ADDR_SIZE       (`FR_FIFO_ADDR_SIZE),
    .ALMOST_FULL_BUF (`FR_META_AFULL_BUF)
  ) meta_fifo_i (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .w_inc         (beat_read_start),
    .w_data        (addr_last),
    .w_full        (),
    .w_almost_full (meta_afull),
    .r_inc         (beat_read_done),
    .r_data        (meta_last),
    .r_empty       ()
  );

  assign res_w_data = '{rlast: meta_last, rdata: mem_r.rdata};

  sync_fifo #(
    .T               (res_entry_t),
    .ADDR_SIZE       (`FR_FIFO_ADDR_SIZE),
    .ALMOST_FULL_BUF (`FR_RES_AFULL_BUF)
  ) res_fifo_i (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .w_inc         (beat_read_done),
    .w_data        (res_w_data),
    .w_full        (),
    .w_almost_full (res_afull),
    .r_inc         (res_r_inc),
    .r_data        (res_r_data),
    .r_empty       (res_r_empty)
  );

  // beat_valid only rises while the FIFO holds data, so the head is the beat
  assign res_r_inc  = beat_valid && beat_ready;
  assign burst_done = res_r_inc && res_r_data.rlast;

  assign beat = '{rdata: res_r_data.rdata, rresp: RESP_OKAY, rlast: res_r_data.rlast};

  // the clear after each transfer wins, which leaves a one cycle bubble
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      beat_valid <= 1'b0;
    end else begin
      if (!res_r_empty) begin
        beat_valid <= 1'b1;
      end
      if (res_r_inc) begin
        beat_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// single clock FIFO, any packed payload type
// the head entry is visible on r_data whenever the FIFO is not empty
module sync_fifo #(
  parameter type T               = logic,
  parameter int  ADDR_SIZE       = 3,
  parameter int  ALMOST_FULL_BUF = 2
) (
  input  logic axi_clk,
  input  logic axi_resetn,
  input  logic w_inc,
  input  T     w_data,
  output logic w_full,
  output logic w_almost_full,
  input  logic r_inc,
  output T     r_data,
  output logic r_empty
);

  localparam int DEPTH = 1 << ADDR_SIZE;

  T mem [DEPTH];

  // pointers carry one extra wrap bit to tell full from empty
  logic [ADDR_SIZE:0] w_ptr;
  logic [ADDR_SIZE:0] r_ptr;
  logic [ADDR_SIZE:0] fill;

  assign fill    = w_ptr - r_ptr;
  assign r_empty = (w_ptr == r_ptr);
  assign w_full  = (w_ptr[ADDR_SIZE] != r_ptr[ADDR_SIZE]) &&
                   (w_ptr[ADDR_SIZE-1:0] == r_ptr[ADDR_SIZE-1:0]);

  // fewer than ALMOST_FULL_BUF free slots left
  assign w_almost_full = (int'(fill) + ALMOST_FULL_BUF) > DEPTH;

  assign r_data = mem[r_ptr[ADDR_SIZE-1:0]];

  // a push onto a full FIFO is dropped, as is a pop from an empty one
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (w_inc && !w_full) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_inc && !r_empty) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  // the slot at the tail pointer takes the payload of every accepted push
  always_ff @(posedge axi_clk) begin
    if (w_inc && !w_full) begin
      mem[w_ptr[ADDR_SIZE-1:0]] <= w_data;
    end
  end

endmodule

`default_nettype wire

/* logic/iter.sv */
`timescale 1ns/1ps
`default_nettype none

// loadable counter that walks from init_val in steps of INC_VAL
// last tells whether the value now held equals max_val
module iter #(
  parameter int WIDTH   = 8,
  parameter int INC_VAL = 1
) (
  input  logic             axi_clk,
  input  logic             init,
  input  logic [WIDTH-1:0] init_val,
  input  logic [WIDTH-1:0] max_val,
  input  logic             inc,
  output logic [WIDTH-1:0] val,
  output logic             last
);

  // the step wraps around modulo 2**WIDTH
  logic [WIDTH-1:0] next_val;

  assign next_val = val + WIDTH'(INC_VAL);

  // last is registered with the value so both always describe the same address
  always_ff @(posedge axi_clk) begin
    if (init) begin
      val  <= init_val;
      last <= (init_val == max_val);
    end else if (inc) begin
      val  <= next_val;
      last <= (next_val == max_val);
    end
  end

endmodule

`default_nettype wire

/* logic/frame_read_pkg.sv */
`default_nettype none

`include "frame_read_config.svh"

package frame_read_pkg;

  // the memory never reports an error, so every response carries this code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // one burst request from the caller, arlenw is zero based
  typedef struct packed {
    logic [`FR_ADDR_WIDTH-1:0]   araddr;
    logic [`FR_ARLENW_WIDTH-1:0] arlenw;
  } rd_req_t;

  // one beat handed back to the caller
  typedef struct packed {
    logic [`FR_DATA_WIDTH-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rlast;
  } rd_beat_t;

  // response of the word memory to one single-beat read
  typedef struct packed {
    logic [`FR_DATA_WIDTH-1:0] rdata;
    logic [1:0]                rresp;
  } mem_r_t;

  // word waiting in the result FIFO together with its last flag
  typedef struct packed {
    logic                      rlast;
    logic [`FR_DATA_WIDTH-1:0] rdata;
  } res_entry_t;

endpackage

`default_nettype wire

/* include/frame_read_config.svh */
`ifndef FRAME_READ_CONFIG_SVH
`define FRAME_READ_CONFIG_SVH

// word address width, the memory holds 2**FR_ADDR_WIDTH words
`define FR_ADDR_WIDTH 8

// width of one memory word
`define FR_DATA_WIDTH 16

// width of the zero-based beat count of a request
`define FR_ARLENW_WIDTH 8

// address step between consecutive beats of a burst
`define FR_STRIDE 2

// log2 of the depth of both reader FIFOs
`define FR_FIFO_ADDR_SIZE 3

// free-entry margins below which a FIFO reports almost full
`define FR_META_AFULL_BUF 2
`define FR_RES_AFULL_BUF 4

`endif
